/* design/moxie_ex_params.svh */
`ifndef MOXIE_EX_PARAMS_SVH
`define MOXIE_EX_PARAMS_SVH

// Data path and address width
`define MOXIE_XLEN 32

// Register file size and index width
`define MOXIE_NREGS 16
`define MOXIE_RIDX_W 4

// Registers with a fixed role in calls and stack operations
`define MOXIE_SP_IDX 1
`define MOXIE_FP_IDX 0

// Halfword offset carried by conditional branches
`define MOXIE_OFS_W 10

`endif

/* design/moxie_pkg.sv */
package moxie_pkg;

  // Decoded operations handled by the execute stage
  typedef enum logic [5:0] {
    OP_NOP  = 6'd0,
    OP_ADD  = 6'd1,
    OP_SUB  = 6'd2,
    OP_AND  = 6'd3,
    OP_OR   = 6'd4,
    OP_XOR  = 6'd5,
    OP_MOV  = 6'd6,
    OP_INC  = 6'd7,
    OP_DEC  = 6'd8,
    OP_LDI  = 6'd9,
    OP_CMP  = 6'd10,
    OP_BEQ  = 6'd11,
    OP_BNE  = 6'd12,
    OP_BLT  = 6'd13,
    OP_BGE  = 6'd14,
    OP_BLE  = 6'd15,
    OP_BGT  = 6'd16,
    OP_BLTU = 6'd17,
    OP_BGEU = 6'd18,
    OP_BLEU = 6'd19,
    OP_BGTU = 6'd20,
    OP_JMP  = 6'd21,
    OP_JMPA = 6'd22,
    OP_JSRA = 6'd23,
    OP_PUSH = 6'd24,
    OP_POP  = 6'd25,
    OP_STA  = 6'd26,
    OP_LDA  = 6'd27
  } opcode_e;

  // Flags left by CMP
  // The lt and gt flags come from signed compares
  typedef struct packed {
    logic eq;
    logic lt;
    logic gt;
    logic ltu;
    logic gtu;
  } cc_t;

  // Call sequencer state
  // The second cycle pushes the frame pointer
  typedef enum logic {
    EX_READY = 1'b0,
    EX_CALL2 = 1'b1
  } ex_state_e;

  // PC-relative branches, as opposed to absolute jumps
  function automatic logic is_cond_branch(input opcode_e op);
    return (op >= OP_BEQ) && (op <= OP_BGTU);
  endfunction

endpackage

/* design/ex_rf_if.sv */
`timescale 1ns/1ns
`include "moxie_ex_params.svh"

interface ex_rf_if;

  // Combinational read side
  logic [`MOXIE_RIDX_W-1:0] rd_idx_a;
  logic [`MOXIE_RIDX_W-1:0] rd_idx_b;
  logic [`MOXIE_XLEN-1:0]   rd_data_a;
  logic [`MOXIE_XLEN-1:0]   rd_data_b;
  logic [`MOXIE_XLEN-1:0]   sp_data;
  logic [`MOXIE_XLEN-1:0]   fp_data;

  // Write side taken at the next rising edge
  logic                     wr_en_a;
  logic [`MOXIE_RIDX_W-1:0] wr_idx_a;
  logic [`MOXIE_XLEN-1:0]   wr_data_a;
  logic                     wr_en_b;
  logic [`MOXIE_RIDX_W-1:0] wr_idx_b;
  logic [`MOXIE_XLEN-1:0]   wr_data_b;

  modport rf_mp (
    input  rd_idx_a, rd_idx_b, wr_en_a, wr_idx_a, wr_data_a, wr_en_b, wr_idx_b, wr_data_b,
    output rd_data_a, rd_data_b, sp_data, fp_data
  );

  modport ex_mp (
    output rd_idx_a, rd_idx_b, wr_en_a, wr_idx_a, wr_data_a, wr_en_b, wr_idx_b, wr_data_b,
    input  rd_data_a, rd_data_b, sp_data, fp_data
  );

endinterface

/* design/moxie_regfile.sv */
`timescale 1ns/1ns
`include "moxie_ex_params.svh"

module moxie_regfile (
  input  logic    clk_i,
  input  logic    rst_i,
  ex_rf_if.rf_mp  rf_i
);

  logic [`MOXIE_XLEN-1:0] regs [`MOXIE_NREGS];

  // Pending write data wins over the stored value with port a on top
  function automatic logic [`MOXIE_XLEN-1:0] rd_port(input logic [`MOXIE_RIDX_W-1:0] idx);
    logic [`MOXIE_XLEN-1:0] val;
    val = regs[idx];
    if (rf_i.wr_en_b && (rf_i.wr_idx_b == idx))
      val = rf_i.wr_data_b;
    if (rf_i.wr_en_a && (rf_i.wr_idx_a == idx))
      val = rf_i.wr_data_a;
    return val;
  endfunction

  always_comb
  begin
    rf_i.rd_data_a = rd_port(rf_i.rd_idx_a);
    rf_i.rd_data_b = rd_port(rf_i.rd_idx_b);
    // Dedicated pointer reads for the call sequence
    rf_i.sp_data   = rd_port(`MOXIE_RIDX_W'(`MOXIE_SP_IDX));
    rf_i.fp_data   = rd_port(`MOXIE_RIDX_W'(`MOXIE_FP_IDX));
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < `MOXIE_NREGS; i++)
        regs[i] <= '0;
    end
    else
    begin
      if (rf_i.wr_en_b)
        regs[rf_i.wr_idx_b] <= rf_i.wr_data_b;
      // Port a is written last so it takes priority
      if (rf_i.wr_en_a)
        regs[rf_i.wr_idx_a] <= rf_i.wr_data_a;
    end
  end

  // The execute stage never aims both ports at one register
  a_wr_idx_distinct: assert property (@(posedge clk_i) disable iff (rst_i)
    (rf_i.wr_en_a && rf_i.wr_en_b) |-> (rf_i.wr_idx_a != rf_i.wr_idx_b))
    else $error("Both write ports target register %0d", rf_i.wr_idx_a);

endmodule

/* design/moxie_branch_unit.sv */
`timescale 1ns/1ns
`include "moxie_ex_params.svh"

module moxie_branch_unit (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  moxie_pkg::opcode_e      op_i,
  input  logic [`MOXIE_XLEN-1:0]  a_i,
  input  logic [`MOXIE_XLEN-1:0]  b_i,
  input  logic [`MOXIE_XLEN-1:0]  pc_i,
  input  logic [`MOXIE_OFS_W-1:0] ofs_i,
  input  logic                    cc_write_i,
  output logic                    taken_o,
  output logic [`MOXIE_XLEN-1:0]  target_o
);

  import moxie_pkg::*;

  cc_t                    cc_q;
  cc_t                    cc_d;
  logic [`MOXIE_XLEN-1:0] rel_target;

  always_comb
  begin
    cc_d.eq  = (a_i == b_i);
    cc_d.lt  = ($signed(a_i) < $signed(b_i));
    cc_d.gt  = ($signed(a_i) > $signed(b_i));
    cc_d.ltu = (a_i < b_i);
    cc_d.gtu = (a_i > b_i);
  end

  // Flags persist until the next CMP
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      cc_q <= '0;
    else if (cc_write_i)
      cc_q <= cc_d;
  end

  always_comb
  begin
    case (op_i)
      OP_BEQ:          taken_o = cc_q.eq;
      OP_BNE:          taken_o = !cc_q.eq;
      OP_BLT:          taken_o = cc_q.lt;
      OP_BGE:          taken_o = cc_q.eq | cc_q.gt;
      OP_BLE:          taken_o = cc_q.eq | cc_q.lt;
      OP_BGT:          taken_o = cc_q.gt;
      OP_BLTU:         taken_o = cc_q.ltu;
      OP_BGEU:         taken_o = cc_q.eq | cc_q.gtu;
      OP_BLEU:         taken_o = cc_q.eq | cc_q.ltu;
      OP_BGTU:         taken_o = cc_q.gtu;
      OP_JMP, OP_JMPA: taken_o = 1'b1;
      default:         taken_o = 1'b0;
    endcase
  end

  // Offset counts halfwords from the end of the 2-byte branch
  assign rel_target = pc_i + `MOXIE_XLEN'd2
                    + {{(`MOXIE_XLEN - `MOXIE_OFS_W - 1){ofs_i[`MOXIE_OFS_W-1]}}, ofs_i, 1'b0};

  // Jumps take a_i, which carries the immediate for JMPA
  assign target_o = is_cond_branch(op_i) ? rel_target : a_i;

endmodule

/* design/moxie_execute.sv */
`timescale 1ns/1ns
`include "moxie_ex_params.svh"

module moxie_execute (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     flush_i,
  input  moxie_pkg::opcode_e       op_i,
  input  logic [`MOXIE_RIDX_W-1:0] ra_i,
  input  logic [`MOXIE_RIDX_W-1:0] rb_i,
  input  logic [`MOXIE_RIDX_W-1:0] rd_i,
  input  logic [`MOXIE_XLEN-1:0]   operand_i,
  input  logic [`MOXIE_XLEN-1:0]   pc_i,
  input  logic [`MOXIE_OFS_W-1:0]  ofs_i,
  ex_rf_if.ex_mp                   rf_o,
  output moxie_pkg::opcode_e       br_op_o,
  output logic [`MOXIE_XLEN-1:0]   br_a_o,
  output logic [`MOXIE_XLEN-1:0]   br_b_o,
  output logic [`MOXIE_XLEN-1:0]   br_pc_o,
  output logic [`MOXIE_OFS_W-1:0]  br_ofs_o,
  output logic                     cc_write_o,
  input  logic                     br_taken_i,
  input  logic [`MOXIE_XLEN-1:0]   br_target_i,
  output logic                     wr_en_a_o,
  output logic [`MOXIE_RIDX_W-1:0] wr_idx_a_o,
  output logic [`MOXIE_XLEN-1:0]   wr_data_a_o,
  output logic                     wr_en_b_o,
  output logic [`MOXIE_RIDX_W-1:0] wr_idx_b_o,
  output logic [`MOXIE_XLEN-1:0]   wr_data_b_o,
  output logic                     mem_we_o,
  output logic                     mem_re_o,
  output logic [`MOXIE_XLEN-1:0]   mem_addr_o,
  output logic [`MOXIE_XLEN-1:0]   mem_data_o,
  output logic                     branch_o,
  output logic [`MOXIE_XLEN-1:0]   branch_target_o
);

  import moxie_pkg::*;

  ex_state_e                state_q;
  logic [`MOXIE_XLEN-1:0]   call_target_q;
  logic                     squash;
  logic                     issue;
  logic [`MOXIE_XLEN-1:0]   a;
  logic [`MOXIE_XLEN-1:0]   b;
  logic [`MOXIE_XLEN-1:0]   alu_res;
  logic                     wa_en_d, wb_en_d, mem_we_d, mem_re_d, branch_d;
  logic [`MOXIE_RIDX_W-1:0] wa_idx_d, wb_idx_d;
  logic [`MOXIE_XLEN-1:0]   wa_data_d, wb_data_d, mem_addr_d, mem_data_d, target_d;

  // Instruction after a taken branch, or under flush, has no effect
  assign squash = branch_o | flush_i;
  assign issue  = (state_q == EX_READY) && !squash;

  assign rf_o.rd_idx_a = ra_i;
  assign rf_o.rd_idx_b = rb_i;
  assign a = rf_o.rd_data_a;
  assign b = rf_o.rd_data_b;

  assign br_op_o    = op_i;
  assign br_a_o     = (op_i == OP_JMPA) ? operand_i : a;
  assign br_b_o     = b;
  assign br_pc_o    = pc_i;
  assign br_ofs_o   = ofs_i;
  assign cc_write_o = issue && (op_i == OP_CMP);

  always_comb
  begin
    case (op_i)
      OP_ADD:  alu_res = a + b;
      OP_SUB:  alu_res = a - b;
      OP_AND:  alu_res = a & b;
      OP_OR:   alu_res = a | b;
      OP_XOR:  alu_res = a ^ b;
      OP_MOV:  alu_res = b;
      OP_INC:  alu_res = a + operand_i;
      OP_DEC:  alu_res = a - operand_i;
      default: alu_res = operand_i;
    endcase
  end

  always_comb
  begin
    wa_en_d    = 1'b0;
    wa_idx_d   = rd_i;
    wa_data_d  = alu_res;
    wb_en_d    = 1'b0;
    wb_idx_d   = ra_i;
    wb_data_d  = a + `MOXIE_XLEN'd4;
    mem_we_d   = 1'b0;
    mem_re_d   = 1'b0;
    mem_addr_d = operand_i;
    mem_data_d = a;
    branch_d   = issue && br_taken_i;
    target_d   = br_target_i;
    if (state_q == EX_CALL2)
    begin
      // Second push of the call starts from the already decremented sp
      wa_en_d    = 1'b1;
      wa_idx_d   = `MOXIE_RIDX_W'(`MOXIE_SP_IDX);
      wa_data_d  = rf_o.sp_data - `MOXIE_XLEN'd4;
      mem_we_d   = 1'b1;
      mem_addr_d = rf_o.sp_data - `MOXIE_XLEN'd4;
      mem_data_d = rf_o.fp_data;
      branch_d   = 1'b1;
      target_d   = call_target_q;
    end
    else if (issue)
    begin
      case (op_i)
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MOV, OP_INC, OP_DEC, OP_LDI:
          wa_en_d = 1'b1;
        OP_PUSH:
        begin
          wa_en_d    = 1'b1;
          wa_idx_d   = ra_i;
          wa_data_d  = a - `MOXIE_XLEN'd4;
          mem_we_d   = 1'b1;
          mem_addr_d = a - `MOXIE_XLEN'd4;
          mem_data_d = b;
        end
        OP_POP:
        begin
          wb_en_d    = 1'b1;
          mem_re_d   = 1'b1;
          mem_addr_d = a;
        end
        OP_STA:  mem_we_d = 1'b1;
        OP_LDA:  mem_re_d = 1'b1;
        OP_JSRA:
        begin
          // Return address goes below the current sp
          wa_en_d    = 1'b1;
          wa_idx_d   = `MOXIE_RIDX_W'(`MOXIE_SP_IDX);
          wa_data_d  = rf_o.sp_data - `MOXIE_XLEN'd4;
          mem_we_d   = 1'b1;
          mem_addr_d = rf_o.sp_data - `MOXIE_XLEN'd4;
          mem_data_d = pc_i + `MOXIE_XLEN'd6;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q   <= EX_READY;
      wr_en_a_o <= 1'b0;
      wr_en_b_o <= 1'b0;
      mem_we_o  <= 1'b0;
      mem_re_o  <= 1'b0;
      branch_o  <= 1'b0;
    end
    else
    begin
      // CALL2 always completes once the first push is out
      state_q   <= (issue && (op_i == OP_JSRA)) ? EX_CALL2 : EX_READY;
      wr_en_a_o <= wa_en_d;
      wr_en_b_o <= wb_en_d;
      mem_we_o  <= mem_we_d;
      mem_re_o  <= mem_re_d;
      branch_o  <= branch_d;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (state_q == EX_READY)
      call_target_q <= operand_i;
    wr_idx_a_o      <= wa_idx_d;
    wr_data_a_o     <= wa_data_d;
    wr_idx_b_o      <= wb_idx_d;
    wr_data_b_o     <= wb_data_d;
    mem_addr_o      <= mem_addr_d;
    mem_data_o      <= mem_data_d;
    branch_target_o <= target_d;
  end

  // Registered strobes double as the register file write enables
  assign rf_o.wr_en_a   = wr_en_a_o;
  assign rf_o.wr_idx_a  = wr_idx_a_o;
  assign rf_o.wr_data_a = wr_data_a_o;
  assign rf_o.wr_en_b   = wr_en_b_o;
  assign rf_o.wr_idx_b  = wr_idx_b_o;
  assign rf_o.wr_data_b = wr_data_b_o;

  a_mem_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(mem_we_o && mem_re_o))
    else $error("Store and load strobes high together");

  a_branch_shadow: assert property (@(posedge clk_i) disable iff (rst_i)
    branch_o |=> !(wr_en_a_o || wr_en_b_o || mem_we_o || mem_re_o || branch_o))
    else $error("Instruction in branch shadow was not squashed");

endmodule

/* design/moxie_ex_top.sv */
`timescale 1ns/1ns
`include "moxie_ex_params.svh"

module moxie_ex_top (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     flush_i,
  input  moxie_pkg::opcode_e       op_i,
  input  logic [`MOXIE_RIDX_W-1:0] ra_i,
  input  logic [`MOXIE_RIDX_W-1:0] rb_i,
  input  logic [`MOXIE_RIDX_W-1:0] rd_i,
  input  logic [`MOXIE_XLEN-1:0]   operand_i,
  input  logic [`MOXIE_XLEN-1:0]   pc_i,
  input  logic [`MOXIE_OFS_W-1:0]  ofs_i,
  output logic                     wr_en_a_o,
  output logic [`MOXIE_RIDX_W-1:0] wr_idx_a_o,
  output logic [`MOXIE_XLEN-1:0]   wr_data_a_o,
  output logic                     wr_en_b_o,
  output logic [`MOXIE_RIDX_W-1:0] wr_idx_b_o,
  output logic [`MOXIE_XLEN-1:0]   wr_data_b_o,
  output logic                     mem_we_o,
  output logic                     mem_re_o,
  output logic [`MOXIE_XLEN-1:0]   mem_addr_o,
  output logic [`MOXIE_XLEN-1:0]   mem_data_o,
  output logic                     branch_o,
  output logic [`MOXIE_XLEN-1:0]   branch_target_o
);

  import moxie_pkg::*;

  opcode_e                 br_op;
  logic [`MOXIE_XLEN-1:0]  br_a, br_b, br_pc, br_target;
  logic [`MOXIE_OFS_W-1:0] br_ofs;
  logic                    cc_write, br_taken;

  ex_rf_if rf_bus ();

  moxie_execute i_moxie_execute (
    .clk_i, .rst_i, .flush_i, .op_i, .ra_i, .rb_i, .rd_i, .operand_i, .pc_i, .ofs_i,
    .rf_o        (rf_bus.ex_mp),
    .br_op_o     (br_op),
    .br_a_o      (br_a),
    .br_b_o      (br_b),
    .br_pc_o     (br_pc),
    .br_ofs_o    (br_ofs),
    .cc_write_o  (cc_write),
    .br_taken_i  (br_taken),
    .br_target_i (br_target),
    .wr_en_a_o, .wr_idx_a_o, .wr_data_a_o, .wr_en_b_o, .wr_idx_b_o, .wr_data_b_o,
    .mem_we_o, .mem_re_o, .mem_addr_o, .mem_data_o, .branch_o, .branch_target_o
  );

  moxie_branch_unit i_moxie_branch_unit (
    .clk_i, .rst_i,
    .op_i       (br_op),
    .a_i        (br_a),
    .b_i        (br_b),
    .pc_i       (br_pc),
    .ofs_i      (br_ofs),
    .cc_write_i (cc_write),
    .taken_o    (br_taken),
    .target_o   (br_target)
  );

  moxie_regfile i_moxie_regfile (
    .clk_i, .rst_i,
    .rf_i (rf_bus.rf_mp)
  );

endmodule

/* verification/moxie_ex_tb.sv */
`timescale 1ns/1ns
`include "moxie_ex_params.svh"

module moxie_ex_tb;

  import moxie_pkg::*;

  typedef logic [`MOXIE_XLEN-1:0]   word_t;
  typedef logic [`MOXIE_RIDX_W-1:0] ridx_t;

  // Roughly four times the cycles the tests take
  localparam int    MAX_CYCLES = 2000;
  localparam ridx_t SP = ridx_t'(`MOXIE_SP_IDX);
  localparam ridx_t FP = ridx_t'(`MOXIE_FP_IDX);

  // Outputs expected one cycle after an instruction is presented
  typedef struct packed {
    logic  wa_en;
    ridx_t wa_idx;
    word_t wa_data;
    logic  wb_en;
    ridx_t wb_idx;
    word_t wb_data;
    logic  we;
    logic  re;
    word_t addr;
    word_t data;
    logic  br;
    word_t target;
  } expect_t;

  logic                    clk_i = 1'b0;
  logic                    rst_i;
  logic                    flush_i;
  opcode_e                 op_i;
  ridx_t                   ra_i;
  ridx_t                   rb_i;
  ridx_t                   rd_i;
  word_t                   operand_i;
  word_t                   pc_i;
  logic [`MOXIE_OFS_W-1:0] ofs_i;
  logic                    wr_en_a_o;
  ridx_t                   wr_idx_a_o;
  word_t                   wr_data_a_o;
  logic                    wr_en_b_o;
  ridx_t                   wr_idx_b_o;
  word_t                   wr_data_b_o;
  logic                    mem_we_o;
  logic                    mem_re_o;
  word_t                   mem_addr_o;
  word_t                   mem_data_o;
  logic                    branch_o;
  word_t                   branch_target_o;

  // Reference model state
  word_t   model_regs [`MOXIE_NREGS];
  cc_t     model_cc;
  logic    squash_next;
  logic    in_call2;
  word_t   call_target;
  expect_t exp_d;
  expect_t exp_q;
  int      err_cnt;
  int      err_mark;
  int      n_pass;
  int      n_fail;
  int      cycles = 0;

  moxie_ex_top i_moxie_ex_top (.*);

  always #50 clk_i = ~clk_i;

  // Expected values move with the DUT registers
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      exp_q <= '0;
    else
      exp_q <= exp_d;
  end

  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout: run stopped after %0d cycles before the tests completed", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input word_t exp_v, input word_t act_v);
    err_cnt++;
    $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
  endtask

  // Output checks on the falling edge
  a_wa_en: assert property (@(negedge clk_i) wr_en_a_o == exp_q.wa_en)
    else report_mismatch("wr_en_a_o", word_t'(exp_q.wa_en), word_t'(wr_en_a_o));
  a_wa_idx: assert property (@(negedge clk_i) exp_q.wa_en |-> wr_idx_a_o == exp_q.wa_idx)
    else report_mismatch("wr_idx_a_o", word_t'(exp_q.wa_idx), word_t'(wr_idx_a_o));
  a_wa_data: assert property (@(negedge clk_i) exp_q.wa_en |-> wr_data_a_o == exp_q.wa_data)
    else report_mismatch("wr_data_a_o", exp_q.wa_data, wr_data_a_o);
  a_wb_en: assert property (@(negedge clk_i) wr_en_b_o == exp_q.wb_en)
    else report_mismatch("wr_en_b_o", word_t'(exp_q.wb_en), word_t'(wr_en_b_o));
  a_wb_idx: assert property (@(negedge clk_i) exp_q.wb_en |-> wr_idx_b_o == exp_q.wb_idx)
    else report_mismatch("wr_idx_b_o", word_t'(exp_q.wb_idx), word_t'(wr_idx_b_o));
  a_wb_data: assert property (@(negedge clk_i) exp_q.wb_en |-> wr_data_b_o == exp_q.wb_data)
    else report_mismatch("wr_data_b_o", exp_q.wb_data, wr_data_b_o);
  a_mem_we: assert property (@(negedge clk_i) mem_we_o == exp_q.we)
    else report_mismatch("mem_we_o", word_t'(exp_q.we), word_t'(mem_we_o));
  a_mem_re: assert property (@(negedge clk_i) mem_re_o == exp_q.re)
    else report_mismatch("mem_re_o", word_t'(exp_q.re), word_t'(mem_re_o));
  a_mem_addr: assert property (@(negedge clk_i)
    (exp_q.we || exp_q.re) |-> mem_addr_o == exp_q.addr)
    else report_mismatch("mem_addr_o", exp_q.addr, mem_addr_o);
  a_mem_data: assert property (@(negedge clk_i) exp_q.we |-> mem_data_o == exp_q.data)
    else report_mismatch("mem_data_o", exp_q.data, mem_data_o);
  a_branch: assert property (@(negedge clk_i) branch_o == exp_q.br)
    else report_mismatch("branch_o", word_t'(exp_q.br), word_t'(branch_o));
  a_target: assert property (@(negedge clk_i) exp_q.br |-> branch_target_o == exp_q.target)
    else report_mismatch("branch_target_o", exp_q.target, branch_target_o);

  // Unsigned forms mirror the signed ones
  function automatic logic cond_holds(input opcode_e op, input cc_t cc);
    case (op)
      OP_BEQ:  return cc.eq;
      OP_BNE:  return !cc.eq;
      OP_BLT:  return cc.lt;
      OP_BGE:  return cc.eq || cc.gt;
      OP_BLE:  return cc.eq || cc.lt;
      OP_BGT:  return cc.gt;
      OP_BLTU: return cc.ltu;
      OP_BGEU: return cc.eq || cc.gtu;
      OP_BLEU: return cc.eq || cc.ltu;
      OP_BGTU: return cc.gtu;
      default: return 1'b0;
    endcase
  endfunction

  // Present one instruction and work out what it should produce
  task automatic step(input opcode_e op, input ridx_t ra, input ridx_t rb, input ridx_t rd,
                      input word_t operand, input word_t pc,
                      input logic [`MOXIE_OFS_W-1:0] ofs, input logic flush);
    expect_t e;
    word_t   a;
    word_t   b;
    word_t   sext;
    @(negedge clk_i);
    flush_i   = flush;
    op_i      = op;
    ra_i      = ra;
    rb_i      = rb;
    rd_i      = rd;
    operand_i = operand;
    pc_i      = pc;
    ofs_i     = ofs;
    a    = model_regs[ra];
    b    = model_regs[rb];
    sext = {{(`MOXIE_XLEN-`MOXIE_OFS_W){ofs[`MOXIE_OFS_W-1]}}, ofs};
    e    = '0;
    if (in_call2)
    begin
      // Second call cycle pushes fp and jumps, whatever is presented
      e.wa_en   = 1'b1;
      e.wa_idx  = SP;
      e.wa_data = model_regs[SP] - 32'd4;
      e.we      = 1'b1;
      e.addr    = model_regs[SP] - 32'd4;
      e.data    = model_regs[FP];
      e.br      = 1'b1;
      e.target  = call_target;
      in_call2  = 1'b0;
    end
    else if (!(flush || squash_next))
    begin
      if (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MOV, OP_INC, OP_DEC, OP_LDI})
      begin
        e.wa_en  = 1'b1;
        e.wa_idx = rd;
      end
      case (op)
        OP_ADD:  e.wa_data = a + b;
        OP_SUB:  e.wa_data = a - b;
        OP_AND:  e.wa_data = a & b;
        OP_OR:   e.wa_data = a | b;
        OP_XOR:  e.wa_data = a ^ b;
        OP_MOV:  e.wa_data = b;
        OP_INC:  e.wa_data = a + operand;
        OP_DEC:  e.wa_data = a - operand;
        OP_LDI:  e.wa_data = operand;
        OP_CMP:
        begin
          model_cc.eq  = (a == b);
          model_cc.lt  = ($signed(a) < $signed(b));
          model_cc.gt  = ($signed(a) > $signed(b));
          model_cc.ltu = (a < b);
          model_cc.gtu = (a > b);
        end
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLE, OP_BGT, OP_BLTU, OP_BGEU, OP_BLEU, OP_BGTU:
        begin
          e.br     = cond_holds(op, model_cc);
          e.target = pc + 32'd2 + (sext << 1);
        end
        OP_JMP:
        begin
          e.br     = 1'b1;
          e.target = a;
        end
        OP_JMPA:
        begin
          e.br     = 1'b1;
          e.target = operand;
        end
        OP_JSRA:
        begin
          e.wa_en     = 1'b1;
          e.wa_idx    = SP;
          e.wa_data   = model_regs[SP] - 32'd4;
          e.we        = 1'b1;
          e.addr      = model_regs[SP] - 32'd4;
          e.data      = pc + 32'd6;
          in_call2    = 1'b1;
          call_target = operand;
        end
        OP_PUSH:
        begin
          e.wa_en   = 1'b1;
          e.wa_idx  = ra;
          e.wa_data = a - 32'd4;
          e.we      = 1'b1;
          e.addr    = a - 32'd4;
          e.data    = b;
        end
        OP_POP:
        begin
          e.wb_en   = 1'b1;
          e.wb_idx  = ra;
          e.wb_data = a + 32'd4;
          e.re      = 1'b1;
          e.addr    = a;
        end
        OP_STA:
        begin
          e.we   = 1'b1;
          e.addr = operand;
          e.data = a;
        end
        OP_LDA:
        begin
          e.re   = 1'b1;
          e.addr = operand;
        end
        default: ;
      endcase
    end
    if (e.wb_en)
      model_regs[e.wb_idx] = e.wb_data;
    if (e.wa_en)
      model_regs[e.wa_idx] = e.wa_data;
    squash_next = e.br;
    exp_d       = e;
  endtask

  function automatic ridx_t rand_reg();
    return ridx_t'($urandom_range(0, `MOXIE_NREGS - 1));
  endfunction

  // ADD through LDI are consecutive opcodes
  task automatic rand_alu(input logic flush);
    step(opcode_e'(6'(OP_ADD) + 6'($urandom_range(0, 8))), rand_reg(), rand_reg(),
         rand_reg(), $urandom, $urandom, '0, flush);
  endtask

  task automatic idle(input int n);
    repeat (n)
      step(OP_NOP, '0, '0, '0, '0, '0, '0, 1'b0);
  endtask

  // Drain the pipeline so the last checks land inside this test
  task automatic close_test(input string name);
    idle(2);
    if (err_cnt == err_mark)
    begin
      n_pass++;
      $display("Test %s: ok", name);
    end
    else
    begin
      n_fail++;
      $display("Test %s: %0d errors", name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  initial
  begin
    word_t x;
    word_t y;
    logic  fl;
    ridx_t r;
    void'($urandom(32'he5aabe53));
    rst_i       = 1'b1;
    flush_i     = 1'b0;
    op_i        = OP_NOP;
    ra_i        = '0;
    rb_i        = '0;
    rd_i        = '0;
    operand_i   = '0;
    pc_i        = '0;
    ofs_i       = '0;
    model_cc    = '0;
    squash_next = 1'b0;
    in_call2    = 1'b0;
    call_target = '0;
    exp_d       = '0;
    err_cnt     = 0;
    err_mark    = 0;
    n_pass      = 0;
    n_fail      = 0;
    for (int i = 0; i < `MOXIE_NREGS; i++)
      model_regs[i] = '0;
    repeat (10) @(negedge clk_i);
    rst_i = 1'b0;

    repeat (200)
      rand_alu(1'b0);
    close_test("reset and ALU write-back");

    for (int i = 0; i < 30; i++)
    begin
      x = $urandom;
      // Equal operands now and then
      y = ($urandom_range(0, 3) == 0) ? x : $urandom;
      step(OP_LDI, '0, '0, 4'd2, x, '0, '0, 1'b0);
      step(OP_LDI, '0, '0, 4'd3, y, '0, '0, 1'b0);
      step(OP_CMP, 4'd2, 4'd3, '0, '0, '0, '0, 1'b0);
      step(opcode_e'(6'(OP_BEQ) + 6'(i % 10)), '0, '0, '0, '0, $urandom,
           `MOXIE_OFS_W'($urandom), 1'b0);
      rand_alu(1'b0);
    end
    close_test("compare and conditional branches");

    for (int i = 0; i < 60; i++)
    begin
      fl = ($urandom_range(0, 3) == 0);
      case ($urandom_range(0, 5))
        0:       step(OP_JMP, rand_reg(), '0, '0, '0, $urandom, '0, fl);
        1:       step(OP_JMPA, '0, '0, '0, $urandom, $urandom, '0, fl);
        default: rand_alu(fl);
      endcase
    end
    close_test("squash after branch and flush");

    step(OP_LDI, '0, '0, SP, 32'h0000_1000, '0, '0, 1'b0);
    for (int i = 0; i < 40; i++)
    begin
      // PUSH, POP, STA and LDA are consecutive opcodes
      r = ($urandom_range(0, 1) == 0) ? SP : rand_reg();
      step(opcode_e'(6'(OP_PUSH) + 6'($urandom_range(0, 3))), r, rand_reg(), '0,
           $urandom, '0, '0, 1'b0);
    end
    close_test("stack and memory access");

    for (int i = 0; i < 5; i++)
    begin
      x = $urandom & 32'hffff_fff0;
      step(OP_LDI, '0, '0, SP, x, '0, '0, 1'b0);
      step(OP_LDI, '0, '0, FP, $urandom, '0, '0, 1'b0);
      step(OP_JSRA, '0, '0, '0, $urandom, $urandom, '0, 1'b0);
      // Ignored in the second call cycle, then squashed
      rand_alu(1'b0);
      rand_alu(1'b0);
      // Register 1 shows up as store data
      step(OP_STA, SP, '0, '0, $urandom, '0, '0, 1'b0);
    end
    close_test("call sequence");

    $display("Tests passed: %0d, failed: %0d, errors: %0d", n_pass, n_fail, err_cnt);
    if ((n_fail == 0) && (err_cnt == 0))
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

/* moxie_ex.f */
+incdir+design
design/moxie_pkg.sv
design/ex_rf_if.sv
design/moxie_regfile.sv
design/moxie_branch_unit.sv
design/moxie_execute.sv
design/moxie_ex_top.sv
verification/moxie_ex_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the execute subsystem testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module moxie_ex_tb -f moxie_ex.f -o moxie_ex_sim

./obj_dir/moxie_ex_sim | tee "$LOG"

if grep -q '\*\*\* PASSED \*\*\*' "$LOG"; then
  echo "Simulation result: pass"
  exit 0
else
  echo "Simulation result: fail, see $LOG"
  exit 1
fi
